// File: hw/csr_bridge_pkg.sv
// CSR bridge shared definitions
`default_nettype none

package csr_bridge_pkg;

  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_ID_WIDTH   = 2;
  localparam int unsigned CSR_DATA_WIDTH = 32;
  localparam int unsigned CSR_ADDR_WIDTH = 8;
  localparam logic [CSR_DATA_WIDTH-1:0] CSR_ID_VALUE = 32'hC5B0_0100;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_REQ  = 2'd1,
    ST_RESP = 2'd2
  } chan_state_e;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
  } axi_ar_t;

  // Same layout as the read address
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [CSR_DATA_WIDTH-1:0]   data;
    logic [CSR_DATA_WIDTH/8-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [CSR_DATA_WIDTH-1:0] data;
    axi_resp_e                 resp;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    axi_resp_e               resp;
  } axi_b_t;

  typedef struct packed {
    logic                        write;
    logic [CSR_ADDR_WIDTH-1:0]   addr;
    logic [CSR_DATA_WIDTH-1:0]   wdata;
    logic [CSR_DATA_WIDTH/8-1:0] strb;
  } csr_req_t;

  typedef struct packed {
    logic                      write;
    logic [CSR_ADDR_WIDTH-1:0] addr;
    logic [CSR_DATA_WIDTH-1:0] wdata;
    logic [CSR_DATA_WIDTH-1:0] biten;
  } csr_bus_req_t;

  typedef struct packed {
    logic                      ack;
    logic                      err;
    logic [CSR_DATA_WIDTH-1:0] rdata;
  } csr_rsp_t;

endpackage

`default_nettype wire

// File: hw/axi_rd_channel.sv
// AXI read channel
`timescale 1ns/1ps
`default_nettype none

module axi_rd_channel
  import csr_bridge_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_ar_t  ar_i,
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  output axi_r_t        r_o,
  output logic          r_valid_o,
  input  wire logic     r_ready_i,
  output logic          req_valid_o,
  output csr_req_t      req_o,
  input  wire logic     done_i,
  input  wire csr_rsp_t rsp_i
);

  chan_state_e state_q;

  logic [AXI_ID_WIDTH-1:0]   id_q;
  logic [CSR_ADDR_WIDTH-1:0] addr_q;
  logic [CSR_DATA_WIDTH-1:0] rdata_q;
  axi_resp_e                 resp_q;

  assign ar_ready_o  = (state_q == ST_IDLE);
  assign req_valid_o = (state_q == ST_REQ);
  assign r_valid_o   = (state_q == ST_RESP);

  assign req_o.write = 1'b0;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = '0;
  assign req_o.strb  = '0;

  assign r_o.id   = id_q;
  assign r_o.data = rdata_q;
  assign r_o.resp = resp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (ar_valid_i) state_q <= ST_REQ;
        ST_REQ:  if (done_i) state_q <= ST_RESP;
        ST_RESP: if (r_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Register port only sees the low address bits
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q   <= ar_i.id;
      addr_q <= ar_i.addr[CSR_ADDR_WIDTH-1:0];
    end
    if (done_i) begin
      rdata_q <= rsp_i.rdata;
      resp_q  <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  a_r_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> $stable(r_o));

endmodule

`default_nettype wire

// File: hw/axi_wr_channel.sv
// AXI write channel
`timescale 1ns/1ps
`default_nettype none

module axi_wr_channel
  import csr_bridge_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_aw_t  aw_i,
  input  wire logic     aw_valid_i,
  output logic          aw_ready_o,
  input  wire axi_w_t   w_i,
  input  wire logic     w_valid_i,
  output logic          w_ready_o,
  output axi_b_t        b_o,
  output logic          b_valid_o,
  input  wire logic     b_ready_i,
  output logic          req_valid_o,
  output csr_req_t      req_o,
  input  wire logic     done_i,
  input  wire csr_rsp_t rsp_i
);

  chan_state_e state_q;
  logic        aw_held_q, w_held_q;
  logic        aw_hs, w_hs;
  logic        have_aw, have_w;

  logic [AXI_ID_WIDTH-1:0]   id_q;
  logic [CSR_ADDR_WIDTH-1:0] addr_q;
  axi_w_t                    w_q;
  axi_resp_e                 resp_q;

  // Each half is accepted once, in either order
  assign aw_ready_o = (state_q == ST_IDLE) && !aw_held_q;
  assign w_ready_o  = (state_q == ST_IDLE) && !w_held_q;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;
  assign have_aw    = aw_held_q || aw_hs;
  assign have_w     = w_held_q || w_hs;

  assign req_valid_o = (state_q == ST_REQ);
  assign b_valid_o   = (state_q == ST_RESP);

  assign req_o.write = 1'b1;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = w_q.data;
  assign req_o.strb  = w_q.strb;

  assign b_o.id   = id_q;
  assign b_o.resp = resp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (have_aw && have_w) begin
            state_q   <= ST_REQ;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
          end else begin
            aw_held_q <= have_aw;
            w_held_q  <= have_w;
          end
        end
        ST_REQ:  if (done_i) state_q <= ST_RESP;
        ST_RESP: if (b_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q   <= aw_i.id;
      addr_q <= aw_i.addr[CSR_ADDR_WIDTH-1:0];
    end
    if (w_hs) w_q <= w_i;
    if (done_i) resp_q <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
  end

  a_done_in_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> state_q == ST_REQ);

endmodule

`default_nettype wire

// File: hw/csr_req_arbiter.sv
// Round-robin register port arbiter
`timescale 1ns/1ps
`default_nettype none

module csr_req_arbiter
  import csr_bridge_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     rd_valid_i,
  input  wire csr_req_t rd_req_i,
  output logic          rd_done_o,
  input  wire logic     wr_valid_i,
  input  wire csr_req_t wr_req_i,
  output logic          wr_done_o,
  output csr_rsp_t      rsp_o,
  output logic          port_req_o,
  output csr_req_t      port_data_o,
  input  wire csr_rsp_t port_rsp_i
);

  logic busy_q;
  logic owner_wr_q;
  logic last_wr_q;
  logic grant_rd, grant_wr;

  // Read wins a tie unless it was served last
  assign grant_rd = !busy_q && rd_valid_i && (!wr_valid_i || last_wr_q);
  assign grant_wr = !busy_q && wr_valid_i && !grant_rd;

  assign port_req_o  = grant_rd || grant_wr;
  assign port_data_o = grant_wr ? wr_req_i : rd_req_i;

  assign rd_done_o = busy_q && !owner_wr_q && port_rsp_i.ack;
  assign wr_done_o = busy_q && owner_wr_q && port_rsp_i.ack;
  assign rsp_o     = port_rsp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      owner_wr_q <= 1'b0;
      last_wr_q  <= 1'b1;
    end else if (port_req_o) begin
      busy_q     <= 1'b1;
      owner_wr_q <= grant_wr;
      last_wr_q  <= grant_wr;
    end else if (port_rsp_i.ack) begin
      busy_q <= 1'b0;
    end
  end

  // An ack with no request in flight would reach neither channel
  a_ack_owned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    port_rsp_i.ack |-> busy_q);

endmodule

`default_nettype wire

// File: hw/csr_port_adapter.sv
// Register port adapter
`timescale 1ns/1ps
`default_nettype none

module csr_port_adapter
  import csr_bridge_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     req_i,
  input  wire csr_req_t req_data_i,
  output csr_rsp_t      rsp_o,
  output logic          bus_req_o,
  output csr_bus_req_t  bus_o,
  input  wire csr_rsp_t bus_rsp_i
);

  logic outstanding_q;

  // A request while one is unanswered never reaches the register block
  assign bus_req_o = req_i && !outstanding_q;

  assign bus_o.write = req_data_i.write;
  assign bus_o.addr  = req_data_i.addr;
  assign bus_o.wdata = req_data_i.wdata;

  for (genvar i = 0; i < CSR_DATA_WIDTH / 8; i++) begin : g_biten
    assign bus_o.biten[i*8+:8] = {8{req_data_i.strb[i]}};
  end

  assign rsp_o = bus_rsp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (bus_req_o) begin
      outstanding_q <= 1'b1;
    end else if (bus_rsp_i.ack) begin
      outstanding_q <= 1'b0;
    end
  end

  a_no_req_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !outstanding_q);

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
// Control and status register block
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
  import csr_bridge_pkg::*;
#(
  parameter int unsigned NUM_RW_REGS = 6
) (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         req_i,
  input  wire csr_bus_req_t bus_i,
  output csr_rsp_t          rsp_o
);

  localparam int unsigned IDX_W  = CSR_ADDR_WIDTH - 2;
  localparam int unsigned CNT_IDX = NUM_RW_REGS;
  localparam int unsigned ID_IDX  = NUM_RW_REGS + 1;

  logic [NUM_RW_REGS-1:0][CSR_DATA_WIDTH-1:0] scratch_q;
  logic [CSR_DATA_WIDTH-1:0] wr_count_q;
  logic [CSR_DATA_WIDTH-1:0] rdata_q;
  logic                      ack_q, err_q;

  logic [IDX_W-1:0]          word_idx;
  logic                      is_rw, is_ro, acc_err, wr_ok;
  logic [CSR_DATA_WIDTH-1:0] rd_data;

  assign word_idx = bus_i.addr[CSR_ADDR_WIDTH-1:2];
  assign is_rw    = word_idx < IDX_W'(NUM_RW_REGS);
  assign is_ro    = (word_idx == IDX_W'(CNT_IDX)) || (word_idx == IDX_W'(ID_IDX));
  assign acc_err  = !is_rw && (bus_i.write || !is_ro);
  assign wr_ok    = req_i && bus_i.write && is_rw;

  always_comb begin
    rd_data = '0;
    if (!bus_i.write) begin
      if (is_rw) rd_data = scratch_q[word_idx];
      else if (word_idx == IDX_W'(CNT_IDX)) rd_data = wr_count_q;
      else if (word_idx == IDX_W'(ID_IDX)) rd_data = CSR_ID_VALUE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scratch_q  <= '0;
      wr_count_q <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      ack_q <= req_i;
      if (req_i) err_q <= acc_err;
      if (wr_ok) begin
        // Only enabled bits change
        scratch_q[word_idx] <= (scratch_q[word_idx] & ~bus_i.biten) |
                               (bus_i.wdata & bus_i.biten);
        wr_count_q <= wr_count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) rdata_q <= acc_err ? '0 : rd_data;
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = err_q;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/csr_bridge_top.sv
// AXI to CSR bridge top
`timescale 1ns/1ps
`default_nettype none

module csr_bridge_top
  import csr_bridge_pkg::*;
#(
  parameter int unsigned NUM_RW_REGS = 6
) (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire axi_ar_t ar_i,
  input  wire logic    ar_valid_i,
  output logic         ar_ready_o,
  output axi_r_t       r_o,
  output logic         r_valid_o,
  input  wire logic    r_ready_i,
  input  wire axi_aw_t aw_i,
  input  wire logic    aw_valid_i,
  output logic         aw_ready_o,
  input  wire axi_w_t  w_i,
  input  wire logic    w_valid_i,
  output logic         w_ready_o,
  output axi_b_t       b_o,
  output logic         b_valid_o,
  input  wire logic    b_ready_i
);

  logic         rd_valid, rd_done, wr_valid, wr_done;
  csr_req_t     rd_req, wr_req, port_data;
  csr_rsp_t     arb_rsp, adapt_rsp, reg_rsp;
  logic         port_req, bus_req;
  csr_bus_req_t bus_data;

  axi_rd_channel rd_chan_i (
    .clk_i, .rst_ni, .ar_i, .ar_valid_i, .ar_ready_o, .r_o, .r_valid_o, .r_ready_i,
    .req_valid_o(rd_valid), .req_o(rd_req), .done_i(rd_done), .rsp_i(arb_rsp)
  );

  axi_wr_channel wr_chan_i (
    .clk_i, .rst_ni, .aw_i, .aw_valid_i, .aw_ready_o, .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .req_valid_o(wr_valid), .req_o(wr_req), .done_i(wr_done), .rsp_i(arb_rsp)
  );

  csr_req_arbiter arb_i (
    .clk_i, .rst_ni,
    .rd_valid_i(rd_valid), .rd_req_i(rd_req), .rd_done_o(rd_done),
    .wr_valid_i(wr_valid), .wr_req_i(wr_req), .wr_done_o(wr_done),
    .rsp_o(arb_rsp), .port_req_o(port_req), .port_data_o(port_data),
    .port_rsp_i(adapt_rsp)
  );

  csr_port_adapter adapter_i (
    .clk_i, .rst_ni, .req_i(port_req), .req_data_i(port_data), .rsp_o(adapt_rsp),
    .bus_req_o(bus_req), .bus_o(bus_data), .bus_rsp_i(reg_rsp)
  );

  csr_regfile #(
    .NUM_RW_REGS(NUM_RW_REGS)
  ) regfile_i (
    .clk_i, .rst_ni, .req_i(bus_req), .bus_i(bus_data), .rsp_o(reg_rsp)
  );

endmodule

`default_nettype wire

// File: bench/tb_csr_bridge.sv
// CSR bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_csr_bridge
  import csr_bridge_pkg::*;
();

  localparam int unsigned NUM_RW_REGS = 6;
  localparam int unsigned WAIT_LIMIT  = 50;
  // Word indices reachable through an 8-bit byte address
  localparam int unsigned NUM_WORDS   = 64;

  logic    clk_i;
  logic    rst_ni;
  axi_ar_t ar_i;
  logic    ar_valid_i, ar_ready_o;
  axi_r_t  r_o;
  logic    r_valid_o, r_ready_i;
  axi_aw_t aw_i;
  logic    aw_valid_i, aw_ready_o;
  axi_w_t  w_i;
  logic    w_valid_i, w_ready_o;
  axi_b_t  b_o;
  logic    b_valid_o, b_ready_i;

  // Expected register map contents
  logic [CSR_DATA_WIDTH-1:0] model_regs [NUM_RW_REGS];
  logic [CSR_DATA_WIDTH-1:0] model_count;
  axi_r_t                    exp_r, r_last;
  axi_b_t                    exp_b, b_last;

  csr_bridge_top #(
    .NUM_RW_REGS(NUM_RW_REGS)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Previous-cycle payloads for the hold checks
  always_ff @(posedge clk_i) begin
    r_last <= r_o;
    b_last <= b_o;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    abort_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, expected,
                        actual));
  endtask

  a_reset_outputs : assert property (@(posedge clk_i) $rose(rst_ni) |->
      {r_valid_o, b_valid_o, ar_ready_o, aw_ready_o, w_ready_o} == 5'b00111)
    else report_mismatch("{r_valid_o,b_valid_o,ar_ready_o,aw_ready_o,w_ready_o}", 64'(5'b00111),
      64'($sampled({r_valid_o, b_valid_o, ar_ready_o, aw_ready_o, w_ready_o})));

  a_r_payload : assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o |-> r_o == exp_r)
    else report_mismatch("r_o", 64'($sampled(exp_r)), 64'($sampled(r_o)));

  a_b_payload : assert property (@(posedge clk_i) disable iff (!rst_ni)
      b_valid_o |-> b_o == exp_b)
    else report_mismatch("b_o", 64'($sampled(exp_b)), 64'($sampled(b_o)));

  a_r_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o && !r_ready_i |=> r_o == r_last)
    else report_mismatch("r_o while stalled", 64'($sampled(r_last)), 64'($sampled(r_o)));

  a_b_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
      b_valid_o && !b_ready_i |=> b_o == b_last)
    else report_mismatch("b_o while stalled", 64'($sampled(b_last)), 64'($sampled(b_o)));

  // Byte-merge into the model; only scratch words accept writes
  function automatic axi_resp_e model_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                            input logic [CSR_DATA_WIDTH-1:0] data,
                                            input logic [3:0] strb);
    int unsigned idx;
    idx = 32'(addr[7:2]);
    if (idx >= NUM_RW_REGS) return RESP_SLVERR;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) model_regs[idx][i*8+:8] = data[i*8+:8];
    end
    model_count++;
    return RESP_OKAY;
  endfunction

  function automatic axi_r_t model_read(input logic [AXI_ID_WIDTH-1:0] id,
                                        input logic [AXI_ADDR_WIDTH-1:0] addr);
    int unsigned idx;
    axi_r_t      r;
    idx    = 32'(addr[7:2]);
    r.id   = id;
    r.data = '0;
    r.resp = RESP_OKAY;
    if (idx < NUM_RW_REGS) r.data = model_regs[idx];
    else if (idx == NUM_RW_REGS) r.data = model_count;
    else if (idx == NUM_RW_REGS + 1) r.data = CSR_ID_VALUE;
    else r.resp = RESP_SLVERR;
    return r;
  endfunction

  // Random bits around the word index, which only bits 7:2 select
  function automatic logic [AXI_ADDR_WIDTH-1:0] word_addr(input int unsigned idx);
    logic [AXI_ADDR_WIDTH-1:0] addr;
    addr      = $urandom();
    addr[7:2] = idx[5:0];
    return addr;
  endfunction

  function automatic logic sig_value(input string name);
    case (name)
      "ar_ready_o": return ar_ready_o;
      "aw_ready_o": return aw_ready_o;
      "w_ready_o":  return w_ready_o;
      "r_valid_o":  return r_valid_o;
      default:      return b_valid_o;
    endcase
  endfunction

  // Entered and left on a falling edge
  task automatic wait_high(input string name);
    int unsigned cycles;
    cycles = 0;
    while (!sig_value(name)) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run($sformatf("Timed out waiting for %s", name));
    end
  endtask

  task automatic send_ar(input axi_ar_t ar);
    ar_i       = ar;
    ar_valid_i = 1'b1;
    wait_high("ar_ready_o");
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic send_aw(input axi_aw_t aw);
    aw_i       = aw;
    aw_valid_i = 1'b1;
    wait_high("aw_ready_o");
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input axi_w_t w);
    w_i       = w;
    w_valid_i = 1'b1;
    wait_high("w_ready_o");
    @(negedge clk_i);
    w_valid_i = 1'b0;
  endtask

  task automatic do_read(input int unsigned idx);
    axi_ar_t ar;
    ar.id   = AXI_ID_WIDTH'($urandom());
    ar.addr = word_addr(idx);
    exp_r   = model_read(ar.id, ar.addr);
    send_ar(ar);
    wait_high("r_valid_o");
    repeat ($urandom_range(4)) @(negedge clk_i);
    r_ready_i = 1'b1;
    @(negedge clk_i);
    r_ready_i = 1'b0;
  endtask

  task automatic do_write(input int unsigned idx);
    axi_aw_t     aw;
    axi_w_t      w;
    int unsigned order;
    aw.id      = AXI_ID_WIDTH'($urandom());
    aw.addr    = word_addr(idx);
    w.data     = $urandom();
    w.strb     = 4'($urandom());
    order      = $urandom_range(2);
    exp_b.id   = aw.id;
    exp_b.resp = model_write(aw.addr, w.data, w.strb);
    if (order == 0) begin
      send_aw(aw);
      send_w(w);
    end else if (order == 1) begin
      send_w(w);
      send_aw(aw);
    end else begin
      fork
        send_aw(aw);
        send_w(w);
      join
    end
    wait_high("b_valid_o");
    repeat ($urandom_range(4)) @(negedge clk_i);
    b_ready_i = 1'b1;
    @(negedge clk_i);
    b_ready_i = 1'b0;
  endtask

  initial begin
    int unsigned a;
    int unsigned b;
    void'($urandom(32'h6cad_e7cb));
    model_count = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    exp_r      = '0;
    exp_b      = '0;
    rst_ni     = 1'b0;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_RW_REGS + 2; i++) do_read(i);

    // Strobed writes, each read back
    repeat (24) begin
      a = $urandom_range(NUM_RW_REGS - 1);
      do_write(a);
      do_read(a);
    end
    do_read(NUM_RW_REGS);

    // Read-only words and holes in the map
    do_write(NUM_RW_REGS);
    do_write(NUM_RW_REGS + 1);
    repeat (6) begin
      a = $urandom_range(NUM_WORDS - 1, NUM_RW_REGS + 2);
      do_write(a);
      do_read(a);
    end
    for (int i = 0; i < NUM_RW_REGS + 2; i++) do_read(i);

    // Read and write started together on different words
    repeat (12) begin
      a = $urandom_range(NUM_RW_REGS - 1);
      b = (a + 1 + $urandom_range(NUM_RW_REGS - 2)) % NUM_RW_REGS;
      fork
        do_read(a);
        do_write(b);
      join
    end
    for (int i = 0; i < NUM_RW_REGS + 2; i++) do_read(i);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/csr_bridge_pkg.sv
hw/axi_rd_channel.sv
hw/axi_wr_channel.sv
hw/csr_req_arbiter.sv
hw/csr_port_adapter.sv
hw/csr_regfile.sv
hw/csr_bridge_top.sv
bench/tb_csr_bridge.sv

// File: Bender.yml
package:
  name: csr_bridge

sources:
  - hw/csr_bridge_pkg.sv
  - hw/axi_rd_channel.sv
  - hw/axi_wr_channel.sv
  - hw/csr_req_arbiter.sv
  - hw/csr_port_adapter.sv
  - hw/csr_regfile.sv
  - hw/csr_bridge_top.sv
  - target: test
    files:
      - bench/tb_csr_bridge.sv
